//--- Bender.yml
package:
  name: mips_decode_pipeline

sources:
  - mips_pkg.sv
  - inst_fetch.sv
  - inst_decoder.sv
  - reg_file.sv
  - decode_stage.sv
  - exec_stage.sv
  - core_top.sv
  - target: test
    files:
      - tb_inst_mem.sv
      - tb_core.sv

//--- core_top.sv
`timescale 1ns/1ns

module core_top import mips_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [xlen-1:0] wb_adr,
    input  logic [31:0]     wb_dat_i,
    input  logic            wb_ack,
    output logic            rf_w_enable,
    output logic [4:0]      rf_w_regnum,
    output logic [xlen-1:0] rf_w_data,
    output logic            reserved_inst
);
    logic            if_valid;
    logic [31:0]     if_inst;
    logic [xlen-1:0] if_pc;
    logic [xlen-1:0] if_pc4;
    logic            id_valid;
    alu_op_t         id_alu_op;
    logic            id_write_enable;
    logic [4:0]      id_w_regnum;
    logic [xlen-1:0] id_a_data;
    logic [xlen-1:0] id_b_data;
    logic            id_beq;
    logic            id_bne;
    logic            id_jump;
    logic [xlen-1:0] id_branch_target;
    logic [xlen-1:0] id_jump_target;
    logic            id_reserved;
    logic            ex_fwd_enable;
    logic [4:0]      ex_fwd_regnum;
    logic [xlen-1:0] ex_fwd_data;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    assign reserved_inst = id_valid && id_reserved;

    inst_fetch #(.xlen(xlen)) fetch0 (
        .clock(clock),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_ack(wb_ack),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .if_valid(if_valid),
        .if_inst(if_inst),
        .if_pc(if_pc),
        .if_pc4(if_pc4)
    );

    decode_stage #(.xlen(xlen)) decode0 (
        .clock(clock),
        .reset(reset),
        .if_valid(if_valid),
        .if_inst(if_inst),
        .if_pc(if_pc),
        .if_pc4(if_pc4),
        .redirect(redirect),
        .ex_fwd_enable(ex_fwd_enable),
        .ex_fwd_regnum(ex_fwd_regnum),
        .ex_fwd_data(ex_fwd_data),
        .wb_enable(rf_w_enable),
        .wb_regnum(rf_w_regnum),
        .wb_data(rf_w_data),
        .id_valid(id_valid),
        .id_alu_op(id_alu_op),
        .id_write_enable(id_write_enable),
        .id_w_regnum(id_w_regnum),
        .id_a_data(id_a_data),
        .id_b_data(id_b_data),
        .id_beq(id_beq),
        .id_bne(id_bne),
        .id_jump(id_jump),
        .id_branch_target(id_branch_target),
        .id_jump_target(id_jump_target),
        .id_reserved(id_reserved)
    );

    exec_stage #(.xlen(xlen)) exec0 (
        .clock(clock),
        .reset(reset),
        .id_valid(id_valid),
        .id_alu_op(id_alu_op),
        .id_write_enable(id_write_enable),
        .id_w_regnum(id_w_regnum),
        .id_a_data(id_a_data),
        .id_b_data(id_b_data),
        .id_beq(id_beq),
        .id_bne(id_bne),
        .id_jump(id_jump),
        .id_branch_target(id_branch_target),
        .id_jump_target(id_jump_target),
        .id_reserved(id_reserved),
        .ex_fwd_enable(ex_fwd_enable),
        .ex_fwd_regnum(ex_fwd_regnum),
        .ex_fwd_data(ex_fwd_data),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .wb_enable(rf_w_enable),
        .wb_regnum(rf_w_regnum),
        .wb_data(rf_w_data)
    );

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage import mips_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            if_valid,
    input  inst_word_t      if_inst,
    input  logic [xlen-1:0] if_pc,
    input  logic [xlen-1:0] if_pc4,
    input  logic            redirect,
    input  logic            ex_fwd_enable,
    input  logic [4:0]      ex_fwd_regnum,
    input  logic [xlen-1:0] ex_fwd_data,
    input  logic            wb_enable,
    input  logic [4:0]      wb_regnum,
    input  logic [xlen-1:0] wb_data,
    output logic            id_valid,
    output alu_op_t         id_alu_op,
    output logic            id_write_enable,
    output logic [4:0]      id_w_regnum,
    output logic [xlen-1:0] id_a_data,
    output logic [xlen-1:0] id_b_data,
    output logic            id_beq,
    output logic            id_bne,
    output logic            id_jump,
    output logic [xlen-1:0] id_branch_target,
    output logic [xlen-1:0] id_jump_target,
    output logic            id_reserved
);
    alu_op_t         alu_op;
    logic            write_enable;
    logic            rd_is_rt;
    logic            imm_is_b;
    logic            sign_extend;
    logic            beq;
    logic            bne;
    logic            jump;
    logic            reserved;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      rd;
    logic [xlen-1:0] ra_data;
    logic [xlen-1:0] rb_data;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] a_data;
    logic [xlen-1:0] b_data;
    logic            load;

    // the execute result is younger than write-back, so it wins.
    function automatic logic [xlen-1:0] forward(input logic [4:0] num,
                                                input logic [xlen-1:0] rf_data);
        if (num != 5'd0 && ex_fwd_enable && ex_fwd_regnum == num) begin
            return ex_fwd_data;
        end
        if (num != 5'd0 && wb_enable && wb_regnum == num) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    inst_decoder decoder0 (
        .inst(if_inst),
        .alu_op(alu_op),
        .write_enable(write_enable),
        .rd_is_rt(rd_is_rt),
        .imm_is_b(imm_is_b),
        .sign_extend(sign_extend),
        .beq(beq),
        .bne(bne),
        .jump(jump),
        .reserved(reserved),
        .rs(rs),
        .rt(rt),
        .rd(rd)
    );

    reg_file #(.xlen(xlen)) regs0 (
        .clock(clock),
        .reset(reset),
        .ra_num(rs),
        .rb_num(rt),
        .ra_data(ra_data),
        .rb_data(rb_data),
        .w_enable(wb_enable),
        .w_num(wb_regnum),
        .w_data(wb_data)
    );

    assign imm_ext = sign_extend ? {{(xlen-16){if_inst.i.imm16[15]}}, if_inst.i.imm16}
                                 : {{(xlen-16){1'b0}}, if_inst.i.imm16};
    assign load = if_valid && !redirect; // a redirect kills the word sitting in IF.

    always_comb begin
        a_data = forward(rs, ra_data);
        b_data = imm_is_b ? imm_ext : forward(rt, rb_data);
        if (reserved) begin
            a_data = if_pc; // a reserved word carries its pc and encoding instead.
            b_data = {{(xlen-32){1'b0}}, if_inst};
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_write_enable <= 1'b0;
            id_beq <= 1'b0;
            id_bne <= 1'b0;
            id_jump <= 1'b0;
            id_reserved <= 1'b0;
        end else begin
            id_valid <= load;
            id_write_enable <= load && write_enable;
            id_beq <= load && beq;
            id_bne <= load && bne;
            id_jump <= load && jump;
            id_reserved <= load && reserved;
        end
    end

    always_ff @(posedge clock) begin
        id_alu_op <= alu_op;
        id_w_regnum <= rd_is_rt ? rt : rd;
        id_a_data <= a_data;
        id_b_data <= b_data;
        id_branch_target <= if_pc4 + {{(xlen-18){if_inst.i.imm16[15]}}, if_inst.i.imm16, 2'b00};
        id_jump_target <= {if_pc4[xlen-1:28], if_inst.r[25:0], 2'b00};
    end

endmodule

//--- exec_stage.sv
`timescale 1ns/1ns

module exec_stage import mips_pkg::*; #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            id_valid,
    input  alu_op_t         id_alu_op,
    input  logic            id_write_enable,
    input  logic [4:0]      id_w_regnum,
    input  logic [xlen-1:0] id_a_data,
    input  logic [xlen-1:0] id_b_data,
    input  logic            id_beq,
    input  logic            id_bne,
    input  logic            id_jump,
    input  logic [xlen-1:0] id_branch_target,
    input  logic [xlen-1:0] id_jump_target,
    input  logic            id_reserved,
    output logic            ex_fwd_enable,
    output logic [4:0]      ex_fwd_regnum,
    output logic [xlen-1:0] ex_fwd_data,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    output logic            wb_enable,
    output logic [4:0]      wb_regnum,
    output logic [xlen-1:0] wb_data
);
    logic [xlen-1:0] alu_out;
    logic            equal;
    logic            taken;

    always_comb begin
        case (id_alu_op)
            alu_sub: alu_out = id_a_data - id_b_data;
            alu_and: alu_out = id_a_data & id_b_data;
            alu_or:  alu_out = id_a_data | id_b_data;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(id_a_data) < $signed(id_b_data)};
            alu_lui: alu_out = {{(xlen-32){id_b_data[15]}}, id_b_data[15:0], 16'h0000};
            default: alu_out = id_a_data + id_b_data;
        endcase
    end

    assign equal = (id_a_data == id_b_data);
    assign taken = (id_beq && equal) || (id_bne && !equal);
    assign redirect = id_valid && (taken || id_jump);
    assign redirect_pc = id_jump ? id_jump_target : id_branch_target;

    assign ex_fwd_enable = id_valid && id_write_enable && !id_reserved;
    assign ex_fwd_regnum = id_w_regnum;
    assign ex_fwd_data = alu_out;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wb_enable <= 1'b0;
        end else begin
            wb_enable <= ex_fwd_enable;
        end
    end

    always_ff @(posedge clock) begin
        wb_regnum <= id_w_regnum;
        wb_data <= alu_out;
    end

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import mips_pkg::*; (
    input  inst_word_t inst,
    output alu_op_t    alu_op,
    output logic       write_enable,
    output logic       rd_is_rt,
    output logic       imm_is_b,
    output logic       sign_extend,
    output logic       beq,
    output logic       bne,
    output logic       jump,
    output logic       reserved,
    output logic [4:0] rs,
    output logic [4:0] rt,
    output logic [4:0] rd
);
    assign rs = inst.i.rs;
    assign rt = inst.i.rt;
    assign rd = inst.r.rd;

    always_comb begin
        alu_op = alu_add;
        write_enable = 1'b0;
        rd_is_rt = 1'b0;
        imm_is_b = 1'b0;
        sign_extend = 1'b0;
        beq = 1'b0;
        bne = 1'b0;
        jump = 1'b0;
        reserved = 1'b0;
        case (inst.r.op)
            op_special: begin
                write_enable = 1'b1;
                case (inst.r.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: reserved = 1'b1;
                endcase
            end
            op_addiu: begin
                write_enable = 1'b1;
                rd_is_rt = 1'b1;
                imm_is_b = 1'b1;
                sign_extend = 1'b1;
            end
            op_ori: begin
                alu_op = alu_or;
                write_enable = 1'b1;
                rd_is_rt = 1'b1;
                imm_is_b = 1'b1;
            end
            op_lui: begin
                alu_op = alu_lui;
                write_enable = 1'b1;
                rd_is_rt = 1'b1;
                imm_is_b = 1'b1;
            end
            op_beq: beq = 1'b1; // both operands come from registers.
            op_bne: bne = 1'b1;
            op_j:   jump = 1'b1;
            default: reserved = 1'b1;
        endcase
        if (reserved) begin
            write_enable = 1'b0;
        end
    end

endmodule

//--- inst_fetch.sv
`timescale 1ns/1ns

module inst_fetch #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [xlen-1:0] wb_adr,
    input  logic [31:0]     wb_dat_i,
    input  logic            wb_ack,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output logic            if_valid,
    output logic [31:0]     if_inst,
    output logic [xlen-1:0] if_pc,
    output logic [xlen-1:0] if_pc4
);
    localparam logic wb_we = 1'b0;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc4;
    logic [xlen-1:0] pending_pc;
    logic            discard;
    logic            accept;
    logic            keep;

    assign wb_adr = pc; // pc only moves on an ack, so the address holds for the whole cycle.
    assign pc4 = pc + xlen'(4);
    assign accept = wb_cyc && wb_stb && wb_ack && !wb_we;
    assign keep = accept && !redirect && !discard;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            pc <= '0;
            discard <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            wb_cyc <= 1'b1; // reads run back to back once out of reset.
            wb_stb <= 1'b1;
            if_valid <= keep;
            if (accept) begin
                discard <= 1'b0;
                if (redirect) begin
                    pc <= redirect_pc;
                end else if (discard) begin
                    pc <= pending_pc; // the stale word is dropped here.
                end else begin
                    pc <= pc4;
                end
            end else if (redirect) begin
                discard <= 1'b1; // let the open read finish, then jump.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (redirect) begin
            pending_pc <= redirect_pc;
        end
        if (keep) begin
            if_inst <= wb_dat_i;
            if_pc <= pc;
            if_pc4 <= pc4;
        end
    end

endmodule

//--- mips_pkg.sv
package mips_pkg;

    // major opcodes.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    // function codes under op_special.
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } reg_view_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } imm_view_t;

    // the jump index is the low 26 bits of the register view.
    typedef union packed {
        reg_view_t r;
        imm_view_t i;
    } inst_word_t;

endpackage

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file #(
    parameter int xlen = 64
) (
    input  logic            clock,
    input  logic            reset,
    input  logic [4:0]      ra_num,
    input  logic [4:0]      rb_num,
    output logic [xlen-1:0] ra_data,
    output logic [xlen-1:0] rb_data,
    input  logic            w_enable,
    input  logic [4:0]      w_num,
    input  logic [xlen-1:0] w_data
);
    logic [xlen-1:0] regs [1:31];

    assign ra_data = (ra_num == 5'd0) ? '0 : regs[ra_num];
    assign rb_data = (rb_num == 5'd0) ? '0 : regs[rb_num];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_enable && w_num != 5'd0) begin
            regs[w_num] <= w_data;
        end
    end

endmodule

//--- tb.f
mips_pkg.sv
inst_fetch.sv
inst_decoder.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
core_top.sv
tb_inst_mem.sv
tb_core.sv

//--- tb_core.sv
`timescale 1ns/1ns

module tb_core import mips_pkg::*; ();
    localparam int xlen = 64;
    localparam int depth = 256;
    localparam int period = 20;

    logic            clock = 1'b0;
    logic            reset;
    logic            wb_cyc;
    logic            wb_stb;
    logic [xlen-1:0] wb_adr;
    logic [31:0]     wb_dat_i;
    logic            wb_ack;
    logic            rf_w_enable;
    logic [4:0]      rf_w_regnum;
    logic [xlen-1:0] rf_w_data;
    logic            reserved_inst;

    logic [31:0]     prog [0:depth-1];
    int              prog_len;
    logic [4:0]      num_q [$];
    logic [xlen-1:0] data_q [$];
    logic [xlen-1:0] target_q [$];
    logic [xlen-1:0] end_pc;
    int              reserved_expected;
    int              reserved_seen;
    int              errors;
    logic            acc_q;
    logic            stb_prev;
    logic [xlen-1:0] adr_prev;
    logic            waiting;
    logic [xlen-1:0] exp_target;
    logic [4:0]      exp_num;
    logic [xlen-1:0] exp_data;

    core_top #(.xlen(xlen)) dut0 (
        .clock(clock),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_ack(wb_ack),
        .rf_w_enable(rf_w_enable),
        .rf_w_regnum(rf_w_regnum),
        .rf_w_data(rf_w_data),
        .reserved_inst(reserved_inst)
    );

    tb_inst_mem #(.xlen(xlen), .depth(depth)) mem0 (
        .clock(clock),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_dat(wb_dat_i),
        .wb_ack(wb_ack)
    );

    always #(period / 2) clock = ~clock;

    function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [25:0] index);
        return {op_j, index};
    endfunction

    task automatic load_program();
        for (int i = 0; i < depth; i++) begin
            prog[i] = 32'hfc00_0000 | 32'(i); // reserved opcode tagged with its own index.
        end
        prog[0]  = i_word(op_addiu, 5'd1, 5'd0, 16'h7fff);
        prog[1]  = i_word(op_addiu, 5'd2, 5'd0, 16'hfffd);
        prog[2]  = r_word(fn_addu, 5'd3, 5'd1, 5'd2);
        prog[3]  = r_word(fn_subu, 5'd4, 5'd2, 5'd1);
        prog[4]  = r_word(fn_and, 5'd5, 5'd3, 5'd4);
        prog[5]  = r_word(fn_or, 5'd6, 5'd5, 5'd1);
        prog[6]  = r_word(fn_slt, 5'd7, 5'd2, 5'd1);
        prog[7]  = r_word(fn_slt, 5'd8, 5'd1, 5'd2);
        prog[8]  = i_word(op_ori, 5'd9, 5'd1, 16'h8001);
        prog[9]  = i_word(op_lui, 5'd10, 5'd0, 16'h8765);
        prog[10] = i_word(op_lui, 5'd11, 5'd0, 16'h1234);
        prog[11] = r_word(fn_addu, 5'd0, 5'd1, 5'd1);
        prog[12] = r_word(fn_addu, 5'd12, 5'd0, 5'd1);
        prog[13] = r_word(6'h3f, 5'd3, 5'd1, 5'd2);
        prog[14] = i_word(op_addiu, 5'd13, 5'd12, 16'd5);
        prog[15] = i_word(op_beq, 5'd13, 5'd13, 16'd2);
        prog[16] = i_word(op_addiu, 5'd14, 5'd0, 16'd1);
        prog[17] = i_word(op_addiu, 5'd15, 5'd0, 16'd2);
        prog[18] = i_word(op_bne, 5'd1, 5'd1, 16'd5);
        prog[19] = i_word(op_ori, 5'd16, 5'd0, 16'h00aa);
        prog[20] = j_word(26'd23);
        prog[21] = i_word(op_addiu, 5'd17, 5'd0, 16'd3);
        prog[23] = r_word(fn_slt, 5'd18, 5'd10, 5'd11);
        prog[24] = i_word(op_bne, 5'd0, 5'd18, 16'd1);
        prog[25] = i_word(op_addiu, 5'd19, 5'd0, 16'd7);
        prog[26] = r_word(fn_subu, 5'd20, 5'd18, 5'd16);
        prog[27] = j_word(26'd27); // the program ends in a jump to itself.
        prog_len = 28;
    endtask

    task automatic run_model();
        logic [xlen-1:0] regs [0:31];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_s;
        logic [xlen-1:0] result;
        logic [4:0]      dest;
        logic            writes;
        logic            reserved;
        inst_word_t      w;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        reserved_expected = 0;
        for (int step = 0; step < 1000; step++) begin
            w = prog[pc[$clog2(depth)+1:2]];
            next_pc = pc + xlen'(4);
            a = regs[w.i.rs];
            b = regs[w.i.rt];
            imm_s = {{(xlen-16){w.i.imm16[15]}}, w.i.imm16};
            result = '0;
            dest = w.i.rt;
            writes = 1'b1;
            reserved = 1'b0;
            case (w.r.op)
                op_special: begin
                    dest = w.r.rd;
                    case (w.r.funct)
                        fn_addu: result = a + b;
                        fn_subu: result = a - b;
                        fn_and:  result = a & b;
                        fn_or:   result = a | b;
                        fn_slt:  result = ($signed(a) < $signed(b)) ? xlen'(1) : '0;
                        default: reserved = 1'b1;
                    endcase
                end
                op_addiu: result = a + imm_s;
                op_ori:   result = a | {{(xlen-16){1'b0}}, w.i.imm16};
                op_lui:   result = {{(xlen-32){w.i.imm16[15]}}, w.i.imm16, 16'h0000};
                op_beq, op_bne: begin
                    writes = 1'b0;
                    if ((a == b) == (w.r.op == op_beq)) begin
                        next_pc = next_pc + {imm_s[xlen-3:0], 2'b00};
                        target_q.push_back(next_pc);
                    end
                end
                op_j: begin
                    writes = 1'b0;
                    next_pc = {next_pc[xlen-1:28], w[25:0], 2'b00};
                    target_q.push_back(next_pc);
                    if (next_pc == pc) begin
                        end_pc = pc;
                        break;
                    end
                end
                default: reserved = 1'b1;
            endcase
            if (reserved) begin
                reserved_expected++;
                writes = 1'b0;
            end
            if (writes) begin
                num_q.push_back(dest); // writes to r0 still show on the port.
                data_q.push_back(result);
                if (dest != 5'd0) begin
                    regs[dest] = result;
                end
            end
            pc = next_pc;
        end
    endtask

    always @(posedge clock) begin
        acc_q <= wb_cyc && wb_stb && wb_ack;
    end

    always @(negedge clock) begin
        if (reset) begin
            assert (!wb_cyc && !wb_stb) else begin
                errors++;
                $display("wishbone cycle or strobe is active while reset is high");
            end
        end else begin
            if (stb_prev && !acc_q) begin
                assert (wb_adr == adr_prev) else begin
                    errors++;
                    $display("Error: wb_adr expected %h got %h", adr_prev, wb_adr);
                end
            end
            if (rf_w_enable) begin
                if (num_q.size() == 0) begin
                    errors++;
                    $display("unexpected register write to r%0d after the last expected write",
                             rf_w_regnum);
                end else begin
                    exp_num = num_q.pop_front();
                    exp_data = data_q.pop_front();
                    assert (rf_w_regnum == exp_num) else begin
                        errors++;
                        $display("Error: rf_w_regnum expected %h got %h", exp_num, rf_w_regnum);
                    end
                    assert (rf_w_data == exp_data) else begin
                        errors++;
                        $display("Error: rf_w_data expected %h got %h", exp_data, rf_w_data);
                    end
                end
            end
            // the first address issued after the redirect is seen must be the target.
            if (waiting && acc_q) begin
                waiting = 1'b0;
                assert (wb_adr == exp_target) else begin
                    errors++;
                    $display("Error: wb_adr expected %h got %h", exp_target, wb_adr);
                end
            end
            if (dut0.redirect) begin
                waiting = 1'b1;
                if (target_q.size() != 0) begin
                    exp_target = target_q.pop_front();
                end else begin
                    exp_target = end_pc;
                end
            end
            if (reserved_inst) begin
                reserved_seen++;
            end
        end
        stb_prev = wb_stb;
        adr_prev = wb_adr;
    end

    initial begin
        wait (prog_len != 0);
        repeat (4 + 40 * prog_len) @(posedge clock);
        $display("timeout after %0d cycles with %0d register writes still missing, %0d errors",
                 4 + 40 * prog_len, num_q.size(), errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        errors = 0;
        reserved_seen = 0;
        waiting = 1'b0;
        stb_prev = 1'b0;
        adr_prev = '0;
        exp_target = '0;
        end_pc = '0;
        prog_len = 0;
        load_program();
        run_model();
        for (int i = 0; i < depth; i++) begin
            mem0.mem[i] = prog[i];
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;
        while (num_q.size() != 0 || target_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock); // extra cycles catch late writes behind the final loop.
        assert (reserved_seen == reserved_expected) else begin
            errors++;
            $display("reserved_inst pulsed %0d times but %0d reserved instructions executed",
                     reserved_seen, reserved_expected);
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb_inst_mem.sv
`timescale 1ns/1ns

module tb_inst_mem #(
    parameter int xlen = 64,
    parameter int depth = 256
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic [xlen-1:0] wb_adr,
    output logic [31:0]     wb_dat,
    output logic            wb_ack
);
    logic [31:0] mem [0:depth-1];
    integer      seed;
    int          wait_left;

    initial begin
        seed = 43289;
        wait_left = 0;
        wb_ack = 1'b0;
        wb_dat = '0;
    end

    // the slave answers on the falling edge, so the master sees a settled ack.
    always @(negedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            if (wb_ack) begin
                wait_left = $unsigned($random(seed)) % 3; // each transfer draws its own wait count.
            end
            if (wb_cyc && wb_stb && wait_left == 0) begin
                wb_ack <= 1'b1; // with no wait states the next transfer is acked right away.
                wb_dat <= mem[wb_adr[$clog2(depth)+1:2]];
            end else begin
                wb_ack <= 1'b0;
                if (wb_cyc && wb_stb) begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule
